// File: Bender.yml
package:
  name: ualink_turbo

sources:
  - hw/ualink_pkg.sv
  - hw/mem_port_if.sv
  - hw/stream_fifo.sv
  - hw/pkt_dispatch.sv
  - hw/mem_write_engine.sv
  - hw/mem_read_engine.sv
  - hw/mem_arbiter.sv
  - hw/ualink_sram.sv
  - hw/ualink_turbo_top.sv
  - target: simulation
    files:
      - verification/ualink_sva.sv
      - verification/ualink_tb.sv

// File: hw/mem_arbiter.sv
// round-robin between the write and the read engine on one ram port
// grant is combinational; write engine wins the first conflict after reset
// rdata goes back to both requesters, each knows when it is valid

`timescale 1ns/1ps

module mem_arbiter (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   mem_port_if.arbiter       wr_port,
   mem_port_if.arbiter       rd_port,
   output logic              ram_we,
   output ualink_pkg::addr_t ram_addr,
   output ualink_pkg::data_t ram_wdata,
   input  ualink_pkg::data_t ram_rdata
);

   logic prio_rd;  // 1 when the read side has priority
   logic wr_gnt;
   logic rd_gnt;

   assign wr_gnt = wr_port.req & (~rd_port.req | ~prio_rd);
   assign rd_gnt = rd_port.req & (~wr_port.req |  prio_rd);

   assign wr_port.gnt = wr_gnt;
   assign rd_port.gnt = rd_gnt;

   // mux the winner onto the ram
   assign ram_we    = (wr_gnt & wr_port.we) | (rd_gnt & rd_port.we);
   assign ram_addr  = rd_gnt ? rd_port.addr  : wr_port.addr;
   assign ram_wdata = rd_gnt ? rd_port.wdata : wr_port.wdata;

   assign wr_port.rdata = ram_rdata;
   assign rd_port.rdata = ram_rdata;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn)
         prio_rd <= 1'b0;
      else if (wr_gnt)
         prio_rd <= 1'b1;
      else if (rd_gnt)
         prio_rd <= 1'b0;
   end

endmodule

// File: hw/mem_port_if.sv
// one requester's view of the shared memory port
// access happens when req and gnt are both high; read data follows a cycle later
// requester keeps req, addr and wdata stable until granted

`timescale 1ns/1ps

interface mem_port_if;

   logic              req;
   logic              we;
   ualink_pkg::addr_t addr;
   ualink_pkg::data_t wdata;
   logic              gnt;
   ualink_pkg::data_t rdata;

   modport requester (output req, we, addr, wdata, input gnt, rdata);
   modport arbiter   (input req, we, addr, wdata, output gnt, rdata);

endinterface

// File: hw/mem_read_engine.sv
// issues burst_words reads from rd_base and pushes the words to the egress fifo
// a read is only issued while the fifo keeps three free entries beyond
// the word still in flight, so a push never meets a full fifo
// rd_start is only legal while rd_busy is low

`timescale 1ns/1ps

module mem_read_engine (
   input  logic                                axi_aclk,
   input  logic                                axi_resetn,
   input  logic                                rd_start,
   input  ualink_pkg::addr_t                   rd_base,
   output logic                                rd_busy,
   mem_port_if.requester                       mem,
   input  logic [ualink_pkg::out_fifo_bits:0]  out_free,
   output logic                                push,
   output ualink_pkg::beat_t                   push_beat
);

   ualink_pkg::addr_t addr_q;
   logic [3:0]        issue_cnt;  // reads granted
   logic [3:0]        ret_cnt;    // words pushed
   logic              pend;       // read data arrives this cycle
   logic              space_ok;

   assign space_ok  = (out_free >= (pend ? 4 : 3));
   assign mem.req   = rd_busy && (issue_cnt < ualink_pkg::burst_words) && space_ok;
   assign mem.we    = 1'b0;
   assign mem.addr  = addr_q;
   assign mem.wdata = '0;

   assign push           = pend;
   assign push_beat.data = mem.rdata;
   assign push_beat.last = (ret_cnt == ualink_pkg::burst_words - 1);

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         rd_busy   <= 1'b0;
         addr_q    <= '0;
         issue_cnt <= '0;
         ret_cnt   <= '0;
         pend      <= 1'b0;
      end else begin
         pend <= mem.req && mem.gnt;  // matches the ram's one-cycle latency
         if (rd_start) begin
            rd_busy   <= 1'b1;
            addr_q    <= rd_base;
            issue_cnt <= '0;
            ret_cnt   <= '0;
         end else begin
            if (mem.req && mem.gnt) begin
               addr_q    <= addr_q + 1'b1;
               issue_cnt <= issue_cnt + 1'b1;
            end
            if (push) begin
               ret_cnt <= ret_cnt + 1'b1;
               if (push_beat.last) rd_busy <= 1'b0;
            end
         end
      end
   end

endmodule

// File: hw/mem_write_engine.sv
// buffers one write beat and stores it at an incrementing address
// address wraps modulo 256; wr_busy means a beat is still waiting for the port

`timescale 1ns/1ps

module mem_write_engine (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  logic              wr_start,
   input  ualink_pkg::addr_t wr_base,
   input  logic              wr_valid,
   input  ualink_pkg::data_t wr_data,
   output logic              wr_ready,
   output logic              wr_busy,
   mem_port_if.requester     mem
);

   logic              buf_valid;
   ualink_pkg::data_t buf_data;
   ualink_pkg::addr_t addr_q;

   assign wr_ready  = ~buf_valid;
   assign wr_busy   = buf_valid;
   assign mem.req   = buf_valid;
   assign mem.we    = buf_valid;
   assign mem.addr  = addr_q;
   assign mem.wdata = buf_data;

   always_ff @(posedge axi_aclk) begin
      if (wr_valid && wr_ready)
         buf_data <= wr_data;
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         buf_valid <= 1'b0;
         addr_q    <= '0;
      end else begin
         if (wr_start) addr_q <= wr_base;
         if (wr_valid && wr_ready) begin
            buf_valid <= 1'b1;
         end else if (mem.req && mem.gnt) begin
            buf_valid <= 1'b0;
            addr_q    <= addr_q + 1'b1;  // next word of the burst
         end
      end
   end

endmodule

// File: hw/pkt_dispatch.sv
// decodes the header beat at the ingress fifo head and hands out jobs
// a read header waits in the fifo until both engines are idle,
// which keeps reads ordered behind earlier writes
// write beats past burst_words and all beats of unknown opcodes are dropped

`timescale 1ns/1ps

module pkt_dispatch (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  ualink_pkg::beat_t head,
   input  logic              empty,
   output logic              pop,
   output logic              wr_start,
   output ualink_pkg::addr_t wr_base,
   output logic              wr_valid,
   output ualink_pkg::data_t wr_data,
   input  logic              wr_ready,
   input  logic              wr_busy,
   output logic              rd_start,
   output ualink_pkg::addr_t rd_base,
   input  logic              rd_busy
);

   typedef enum logic [1:0] {st_idle, st_write, st_drop, st_read_wait} state_t;

   state_t              state;
   state_t              state_next;
   logic [3:0]          beat_cnt;   // data beats forwarded in this packet
   ualink_pkg::opcode_t opcode;
   logic                room;

   assign opcode   = head.data[ualink_pkg::data_w-1 -: $bits(ualink_pkg::opcode_t)];
   assign wr_base  = head.data[ualink_pkg::addr_w-1:0];
   assign rd_base  = head.data[ualink_pkg::addr_w-1:0];
   assign wr_data  = head.data;
   assign room     = (beat_cnt < ualink_pkg::burst_words);

   always_comb begin
      state_next = state;
      pop        = 1'b0;
      wr_start   = 1'b0;
      wr_valid   = 1'b0;
      rd_start   = 1'b0;
      case (state)
         st_idle: begin
            if (!empty) begin
               if (opcode == ualink_pkg::op_write) begin
                  if (!wr_busy) begin  // previous burst fully written
                     pop      = 1'b1;
                     wr_start = 1'b1;
                     if (!head.last) state_next = st_write;
                  end
               end else if (opcode == ualink_pkg::op_read) begin
                  state_next = st_read_wait;
               end else begin
                  pop = 1'b1;
                  if (!head.last) state_next = st_drop;
               end
            end
         end
         st_write: begin
            if (!empty) begin
               if (room) begin
                  wr_valid = 1'b1;
                  pop      = wr_ready;
               end else begin
                  pop = 1'b1;  // excess beat
               end
               if (pop && head.last) state_next = st_idle;
            end
         end
         st_drop: begin
            if (!empty) begin
               pop = 1'b1;
               if (head.last) state_next = st_idle;
            end
         end
         st_read_wait: begin
            if (!wr_busy && !rd_busy) begin
               pop        = 1'b1;
               rd_start   = 1'b1;
               state_next = head.last ? st_idle : st_drop;
            end
         end
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state    <= st_idle;
         beat_cnt <= '0;
      end else begin
         state <= state_next;
         if (wr_start)
            beat_cnt <= '0;
         else if (state == st_write && pop && room)
            beat_cnt <= beat_cnt + 1'b1;
      end
   end

endmodule

// File: hw/stream_fifo.sv
// first-word-fall-through fifo of stream beats
// nearly_full when two or fewer entries are free
// writes while full and reads while empty are ignored

`timescale 1ns/1ps

module stream_fifo #(
   parameter int DEPTH_BITS = 4
) (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  ualink_pkg::beat_t     din,
   input  logic                  wr_en,
   input  logic                  rd_en,
   output ualink_pkg::beat_t     dout,
   output logic                  empty,
   output logic                  nearly_full,
   output logic [DEPTH_BITS:0]   free_count
);

   ualink_pkg::beat_t      buf_mem [2**DEPTH_BITS];
   logic [DEPTH_BITS-1:0]  wr_ptr;
   logic [DEPTH_BITS-1:0]  rd_ptr;
   logic [DEPTH_BITS:0]    count;
   logic                   full;
   logic                   do_wr;
   logic                   do_rd;

   assign full        = count[DEPTH_BITS];  // count == depth
   assign empty       = (count == '0);
   assign free_count  = {1'b1, {DEPTH_BITS{1'b0}}} - count;
   assign nearly_full = (free_count <= 2);
   assign do_wr       = wr_en & ~full;
   assign do_rd       = rd_en & ~empty;
   assign dout        = buf_mem[rd_ptr];   // head visible without a pop

   always_ff @(posedge axi_aclk) begin
      if (do_wr)
         buf_mem[wr_ptr] <= din;
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         count <= count + do_wr - do_rd;
      end
   end

endmodule

// File: hw/ualink_pkg.sv
// shared widths, opcodes and the stream beat type for the command engine
// memory is 256 x 64, bursts are fixed at 8 words
// header opcode sits in bits 63:48, base address in bits 7:0

package ualink_pkg;

   localparam int data_w      = 64;
   localparam int addr_w      = 8;
   localparam int burst_words = 8;

   // header opcodes
   localparam logic [15:0] op_write = 16'h0245;
   localparam logic [15:0] op_read  = 16'h0145;

   // fifo depths as log2
   localparam int in_fifo_bits  = 5;  // 32 entries
   localparam int out_fifo_bits = 4;  // 16 entries

   typedef logic [data_w-1:0] data_t;
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [15:0]       opcode_t;

   // one stream beat, payload of both fifos
   typedef struct packed {
      data_t data;
      logic  last;
   } beat_t;

endpackage

// File: hw/ualink_sram.sv
// 256 x 64 single-port storage, registered read
// read-before-write when addr hits a word being written

`timescale 1ns/1ps

module ualink_sram (
   input  logic              axi_aclk,
   input  logic              we,
   input  ualink_pkg::addr_t addr,
   input  ualink_pkg::data_t wdata,
   output ualink_pkg::data_t rdata
);

   ualink_pkg::data_t ram [2**ualink_pkg::addr_w];

   always_ff @(posedge axi_aclk) begin
      if (we)
         ram[addr] <= wdata;
      rdata <= ram[addr];  // valid one cycle after the access
   end

endmodule

// File: hw/ualink_turbo_top.sv
// command engine top: one AXI-Stream ingress for commands, one egress for read data
// no tuser/tstrb; egress words carry tlast on the eighth word of each response
// s_axis_tready drops when the ingress fifo has two or fewer free entries

`timescale 1ns/1ps

module ualink_turbo_top (
   input  logic              axi_aclk,
   input  logic              axi_resetn,
   input  ualink_pkg::data_t s_axis_tdata,
   input  logic              s_axis_tvalid,
   input  logic              s_axis_tlast,
   output logic              s_axis_tready,
   output ualink_pkg::data_t m_axis_tdata,
   output logic              m_axis_tvalid,
   output logic              m_axis_tlast,
   input  logic              m_axis_tready
);

   ualink_pkg::beat_t in_beat;
   ualink_pkg::beat_t in_head;
   logic              in_empty;
   logic              in_nearly_full;
   logic              in_pop;

   logic              wr_start;
   ualink_pkg::addr_t wr_base;
   logic              wr_valid;
   ualink_pkg::data_t wr_data;
   logic              wr_ready;
   logic              wr_busy;
   logic              rd_start;
   ualink_pkg::addr_t rd_base;
   logic              rd_busy;

   ualink_pkg::beat_t                  out_beat;
   ualink_pkg::beat_t                  out_head;
   logic                               out_push;
   logic                               out_empty;
   logic [ualink_pkg::out_fifo_bits:0] out_free;

   logic              ram_we;
   ualink_pkg::addr_t ram_addr;
   ualink_pkg::data_t ram_wdata;
   ualink_pkg::data_t ram_rdata;

   mem_port_if wr_mem ();
   mem_port_if rd_mem ();

   assign in_beat       = '{data: s_axis_tdata, last: s_axis_tlast};
   assign s_axis_tready = ~in_nearly_full;
   assign m_axis_tdata  = out_head.data;
   assign m_axis_tlast  = out_head.last;
   assign m_axis_tvalid = ~out_empty;

   stream_fifo #(.DEPTH_BITS(ualink_pkg::in_fifo_bits)) in_fifo (
      .axi_aclk, .axi_resetn,
      .din(in_beat), .wr_en(s_axis_tvalid & s_axis_tready), .rd_en(in_pop),
      .dout(in_head), .empty(in_empty), .nearly_full(in_nearly_full), .free_count());

   pkt_dispatch dispatch0 (
      .axi_aclk, .axi_resetn, .head(in_head), .empty(in_empty), .pop(in_pop),
      .wr_start, .wr_base, .wr_valid, .wr_data, .wr_ready, .wr_busy,
      .rd_start, .rd_base, .rd_busy);

   mem_write_engine wr_eng0 (
      .axi_aclk, .axi_resetn, .wr_start, .wr_base, .wr_valid, .wr_data,
      .wr_ready, .wr_busy, .mem(wr_mem.requester));

   mem_read_engine rd_eng0 (
      .axi_aclk, .axi_resetn, .rd_start, .rd_base, .rd_busy, .mem(rd_mem.requester),
      .out_free, .push(out_push), .push_beat(out_beat));

   mem_arbiter arb0 (
      .axi_aclk, .axi_resetn, .wr_port(wr_mem.arbiter), .rd_port(rd_mem.arbiter),
      .ram_we, .ram_addr, .ram_wdata, .ram_rdata);

   ualink_sram sram0 (
      .axi_aclk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata));

   stream_fifo #(.DEPTH_BITS(ualink_pkg::out_fifo_bits)) out_fifo (
      .axi_aclk, .axi_resetn,
      .din(out_beat), .wr_en(out_push), .rd_en(m_axis_tvalid & m_axis_tready),
      .dout(out_head), .empty(out_empty), .nearly_full(), .free_count(out_free));

endmodule

// File: sources.f
hw/ualink_pkg.sv
hw/mem_port_if.sv
hw/stream_fifo.sv
hw/pkt_dispatch.sv
hw/mem_write_engine.sv
hw/mem_read_engine.sv
hw/mem_arbiter.sv
hw/ualink_sram.sv
hw/ualink_turbo_top.sv
verification/ualink_sva.sv
verification/ualink_tb.sv

// File: verification/ualink_golden.hex
// kind (0 beat to send, 1 expected egress word)  last  data
// writes at 0x10 and 0xfc, unknown op at 0x10, ten-beat write at 0xf4, reads of 0x10 and 0xfc
0 0 0245000000000010
0 0 1000000000000000
0 0 1000000000000001
0 0 1000000000000002
0 0 1000000000000003
0 0 1000000000000004
0 0 1000000000000005
0 0 1000000000000006
0 1 1000000000000007
0 0 02450000000000fc
0 0 20000000000000fc
0 0 20000000000000fd
0 0 20000000000000fe
0 0 20000000000000ff
0 0 2000000000000000
0 0 2000000000000001
0 0 2000000000000002
0 1 2000000000000003
0 0 0999000000000010
0 1 dead00000000beef
0 0 02450000000000f4
0 0 30000000000000f4
0 0 30000000000000f5
0 0 30000000000000f6
0 0 30000000000000f7
0 0 30000000000000f8
0 0 30000000000000f9
0 0 30000000000000fa
0 0 30000000000000fb
0 0 3bad000000000001
0 1 3bad000000000002
0 1 0145000000000010
0 1 01450000000000fc
1 0 1000000000000000
1 0 1000000000000001
1 0 1000000000000002
1 0 1000000000000003
1 0 1000000000000004
1 0 1000000000000005
1 0 1000000000000006
1 1 1000000000000007
1 0 20000000000000fc
1 0 20000000000000fd
1 0 20000000000000fe
1 0 20000000000000ff
1 0 2000000000000000
1 0 2000000000000001
1 0 2000000000000002
1 1 2000000000000003

// File: verification/ualink_sva.sv
// grant checks for the round-robin memory arbiter
// bound into every mem_arbiter instance, checks are off during reset

`timescale 1ns/1ps

module ualink_arb_sva (
   input logic axi_aclk,
   input logic axi_resetn,
   input logic wr_req,
   input logic rd_req,
   input logic wr_gnt,
   input logic rd_gnt,
   input logic ram_we
);

   a_one_gnt: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(wr_gnt && rd_gnt)) else $error("arbiter granted both requesters");

   a_wr_req: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      wr_gnt |-> wr_req) else $error("write grant without a write request");

   a_rd_req: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      rd_gnt |-> rd_req) else $error("read grant without a read request");

   // only the write engine may store
   a_we_owner: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      ram_we |-> wr_gnt) else $error("ram write while the write port is not granted");

endmodule

bind mem_arbiter ualink_arb_sva arb_sva0 (
   .axi_aclk, .axi_resetn, .wr_req(wr_port.req), .rd_req(rd_port.req),
   .wr_gnt, .rd_gnt, .ram_we);

// File: verification/ualink_tb.sv
// drives command beats from the golden file and checks egress words in order
// golden path is relative to the project root; m_axis_tready toggles randomly
// expects every response word exactly once, extra or missing words fail

`timescale 1ns/1ps

module ualink_tb;

   localparam int beat_timeout = 2000;   // cycles a single beat may wait for tready
   localparam int run_timeout  = 20000;

   logic              axi_aclk;
   logic              axi_resetn;
   ualink_pkg::data_t s_axis_tdata;
   logic              s_axis_tvalid;
   logic              s_axis_tlast;
   logic              s_axis_tready;
   ualink_pkg::data_t m_axis_tdata;
   logic              m_axis_tvalid;
   logic              m_axis_tlast;
   logic              m_axis_tready;

   ualink_pkg::beat_t send_q [$];
   ualink_pkg::beat_t exp_q [$];
   int                exp_idx;
   int                val_errs;
   int                other_errs;
   bit                send_done;
   bit                timed_out;
   integer            seed = 32'h2bda;
   string             test_names [2] = '{"read_0x10_after_unknown_and_excess", "read_0xfc_wrap"};

   ualink_turbo_top dut0 (
      .axi_aclk, .axi_resetn,
      .s_axis_tdata, .s_axis_tvalid, .s_axis_tlast, .s_axis_tready,
      .m_axis_tdata, .m_axis_tvalid, .m_axis_tlast, .m_axis_tready);

   initial begin
      axi_aclk = 1'b0;
      forever #50 axi_aclk = ~axi_aclk;
   end

   // egress back-pressure, ready about one cycle in eight
   // slow enough that the egress fifo fills and the read engine stalls
   initial begin
      m_axis_tready = 1'b0;
      forever begin
         @(posedge axi_aclk);
         #5 m_axis_tready = (($random(seed) % 8) == 0);
      end
   end

   task load_golden;
      int                fd;
      string             line;
      int                kind;
      int                last;
      ualink_pkg::data_t data;
      ualink_pkg::beat_t b;
      fd = $fopen("verification/ualink_golden.hex", "r");
      if (fd == 0) begin
         $display("cannot open verification/ualink_golden.hex");
         other_errs++;
      end else begin
         while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%h %h %h", kind, last, data) == 3) begin  // skips comments
               b.data = data;
               b.last = last[0];
               if (kind == 0) send_q.push_back(b);
               else           exp_q.push_back(b);
            end
         end
         $fclose(fd);
      end
      if (exp_q.size() == 0) begin
         $display("golden file holds no expected response words");
         other_errs++;
      end
   endtask

   task check_beat(input string name, input ualink_pkg::beat_t exp, input ualink_pkg::beat_t act);
      if (act !== exp) begin
         $display("ERROR %s: expected data=%h last=%b, actual data=%h last=%b",
                  name, exp.data, exp.last, act.data, act.last);
         val_errs++;
      end
   endtask

   // called just after a rising edge; one beat per accepted handshake
   task drive_beats;
      int wait_cnt;
      foreach (send_q[i]) begin
         s_axis_tdata  = send_q[i].data;
         s_axis_tlast  = send_q[i].last;
         s_axis_tvalid = 1'b1;
         wait_cnt      = 0;
         @(negedge axi_aclk);
         while (!s_axis_tready && wait_cnt < beat_timeout) begin
            wait_cnt++;
            @(negedge axi_aclk);
         end
         if (wait_cnt >= beat_timeout) begin
            $display("timeout: s_axis_tready stayed low at ingress beat %0d", i);
            other_errs++;
            timed_out = 1'b1;
            break;
         end
         @(posedge axi_aclk);
         #5;
      end
      s_axis_tvalid = 1'b0;
      send_done     = 1'b1;
   endtask

   // sampled mid-cycle, the handshake happens on the next rising edge
   always @(negedge axi_aclk) begin : egress_monitor
      ualink_pkg::beat_t got;
      string             name;
      if (axi_resetn === 1'b1 && m_axis_tvalid === 1'b1 && m_axis_tready) begin
         got.data = m_axis_tdata;
         got.last = m_axis_tlast;
         if (exp_q.size() == 0) begin
            $display("unexpected egress word data=%h last=%b", got.data, got.last);
            other_errs++;
         end else begin
            name = (exp_idx / 8 < 2) ? test_names[exp_idx / 8] : "extra_read";
            check_beat($sformatf("%s word %0d", name, exp_idx % 8), exp_q.pop_front(), got);
            exp_idx++;
         end
      end
   end

   initial begin : main
      int cycles;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      load_golden();
      repeat (2) @(posedge axi_aclk);
      #5 axi_resetn = 1'b1;
      fork
         drive_beats();
      join_none
      cycles = 0;
      while (!(send_done && exp_q.size() == 0) && !timed_out && cycles < run_timeout) begin
         @(posedge axi_aclk);
         cycles++;
      end
      if (cycles >= run_timeout) begin
         $display("timeout: %0d expected words never arrived", exp_q.size());
         other_errs++;
      end
      repeat (40) @(posedge axi_aclk);  // window for stray egress words
      if (m_axis_tvalid !== 1'b0) begin
         $display("egress still offers a word after the expected list ended");
         other_errs++;
      end
      $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
      if (val_errs == 0 && other_errs == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
